//--- run.sh
#!/bin/bash
# Build with Verilator, run, then scan the log for the failure line
set -o pipefail
verilator --binary --assert --timescale 1ns/1ps --top-module tb_mem_subsys \
    -f src.f -o sim_mem_subsys \
    && ./obj_dir/sim_mem_subsys | tee sim.log \
    && ! grep -q "Test failed" sim.log \
    && echo "Simulation run clean" \
    || { echo "Simulation run reported a failure"; exit 1; }

//--- source/channel_arb.sv
`timescale 1ns/1ps

module channel_arb (
    input  logic                        clk,                  // Only for the checks below
    input  logic                        arst_n,
    // pc channel
    input  logic                        pc_index_valid,
    input  logic [mem_pkg::INDEX_W-1:0] pc_index,
    output logic                        pc_index_ready,
    // opstore channel
    input  logic                        opstore_index_valid,
    input  logic [mem_pkg::INDEX_W-1:0] opstore_index,
    output logic                        opstore_index_ready,
    input  logic [mem_pkg::WORD_W-1:0]  opstore_write_mask,
    input  logic [mem_pkg::WORD_W-1:0]  opstore_write_data,
    // opload channel
    input  logic                        opload_index_valid,
    input  logic [mem_pkg::INDEX_W-1:0] opload_index,
    output logic                        opload_index_ready,
    // Memory port
    input  logic                        ddr_ready,
    output logic                        ddr_chip_enable,
    output mem_pkg::ddr_req_t           ddr_req
);
    import mem_pkg::*;

    always_comb begin
        ddr_chip_enable     = 1'b0;           // Idle port by default
        ddr_req             = '0;             // No winner gives an all-zero request
        pc_index_ready      = 1'b0;
        opstore_index_ready = 1'b0;
        opload_index_ready  = 1'b0;

        if (ddr_ready) begin                  // Nothing is granted while the controller is busy
            if (opstore_index_valid) begin    // Store has top priority
                ddr_chip_enable     = 1'b1;
                ddr_req.index       = opstore_index;
                ddr_req.write       = 1'b1;
                ddr_req.mask        = opstore_write_mask;
                ddr_req.data        = opstore_write_data;
                opstore_index_ready = 1'b1;
            end else if (opload_index_valid) begin
                ddr_chip_enable    = 1'b1;
                ddr_req.index      = opload_index;   // Single word read
                opload_index_ready = 1'b1;
            end else if (pc_index_valid) begin       // Fetch only when the LSU is quiet
                ddr_chip_enable = 1'b1;
                ddr_req.index   = pc_index;
                ddr_req.burst   = 1'b1;              // Whole line for the fetch unit
                pc_index_ready  = 1'b1;
            end
        end
    end

    // Only one client may see its grant in a cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({pc_index_ready, opstore_index_ready, opload_index_ready}))
        else $error("channel_arb: more than one ready high");

    // A request is only presented to an idle controller
    assert property (@(posedge clk) disable iff (!arst_n)
        ddr_chip_enable |-> ddr_ready)
        else $error("channel_arb: chip enable while memory not ready");

endmodule

//--- source/ddr_bank.sv
`timescale 1ns/1ps

module ddr_bank (
    input  logic              clk,
    input  logic              bank_we,
    input  logic              bank_re,
    input  mem_pkg::ddr_req_t bank_req,
    output mem_pkg::line_t    bank_line
);
    import mem_pkg::*;

    logic [WORD_W-1:0]                     mem [BANK_DEPTH];   // Model array
    logic [BANK_DEPTH_LOG2-1:0]            word_addr;          // Wrapped word index
    logic [BANK_DEPTH_LOG2-WORD_SEL_W-1:0] line_addr;          // Aligned line number

    assign word_addr = bank_req.index[BANK_DEPTH_LOG2-1:0];    // Upper index bits alias
    assign line_addr = word_addr[BANK_DEPTH_LOG2-1:WORD_SEL_W];

    // Bit-masked word write
    always_ff @(posedge clk) begin
        if (bank_we) begin
            mem[word_addr] <= (mem[word_addr] & ~bank_req.mask)
                            | (bank_req.data & bank_req.mask);
        end
    end

    // Line read lands one cycle after the strobe
    always_ff @(posedge clk) begin
        if (bank_re) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                bank_line.words[w] <= mem[{line_addr, WORD_SEL_W'(w)}];
            end
        end
    end

    // Controller issues a single access at a time
    assert property (@(posedge clk) !(bank_we && bank_re))
        else $error("ddr_bank: write and read in the same cycle");

endmodule

//--- source/ddr_ctrl.sv
`timescale 1ns/1ps

module ddr_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ddr_chip_enable,
    input  mem_pkg::ddr_req_t           ddr_req,
    input  mem_pkg::line_t              bank_line,
    output logic                        ddr_ready,
    output logic                        ddr_operation_done,
    output logic                        bank_we,
    output logic                        bank_re,
    output mem_pkg::ddr_req_t           bank_req,
    output logic [mem_pkg::LINE_W-1:0]  pc_read_inst,
    output logic [mem_pkg::WORD_W-1:0]  opload_read_data
);
    import mem_pkg::*;

    logic                 busy_q;       // One request in flight
    logic [DDR_CNT_W-1:0] cnt_q;        // Cycles since the grant edge
    logic                 grant;
    logic                 access_cyc;   // Bank strobe on the last busy cycle
    logic                 capture_cyc;  // Bank line valid
    logic                 done_cyc;

    assign grant       = ddr_chip_enable && !busy_q;
    assign access_cyc  = busy_q && (cnt_q == CNT_ACCESS);
    assign capture_cyc = busy_q && (cnt_q == CNT_CAPTURE);
    assign done_cyc    = busy_q && (cnt_q == CNT_DONE);

    assign ddr_ready          = !busy_q;                     // Ready again right after done
    assign ddr_operation_done = done_cyc;                    // Broadcast to all clients
    assign bank_we            = access_cyc && bank_req.write;
    assign bank_re            = access_cyc && !bank_req.write;

    // Busy flag and latency counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (grant) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;                 // First busy cycle sees zero
        end else if (done_cyc) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Request held for the whole access
    always_ff @(posedge clk) begin
        if (grant) begin
            bank_req <= ddr_req;
        end
    end

    // Read results stay put until the next read of the same kind
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_read_inst     <= '0;
            opload_read_data <= '0;
        end else if (capture_cyc && !bank_req.write) begin
            if (bank_req.burst) begin
                pc_read_inst <= bank_line.flat;      // Full aligned line for fetch
            end else begin
                // Load picks its word out of the line
                opload_read_data <= bank_line.words[bank_req.index[WORD_SEL_W-1:0]];
            end
        end
    end

    // Arbiter must hold off while an access is running
    assert property (@(posedge clk) disable iff (!arst_n)
        ddr_chip_enable |-> !busy_q)
        else $error("ddr_ctrl: chip enable while busy");

    // Fixed turnaround from grant to done
    assert property (@(posedge clk) disable iff (!arst_n)
        grant |-> ##(DDR_LATENCY + 2) ddr_operation_done)
        else $error("ddr_ctrl: done not seen at the expected cycle");

endmodule

//--- source/mem_pkg.sv
package mem_pkg;

    // Client and bus sizes
    localparam int INDEX_W    = 19;                    // Word index width on every channel
    localparam int WORD_W     = 64;                    // Data word width
    localparam int LINE_WORDS = 8;                     // Words per burst line
    localparam int LINE_W     = WORD_W * LINE_WORDS;   // 512-bit instruction line
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);    // Word select inside a line

    // Storage model
    localparam int BANK_DEPTH_LOG2 = 10;                    // Index bits the array really decodes
    localparam int BANK_DEPTH      = 1 << BANK_DEPTH_LOG2;  // Words in the array

    // Controller timing model
    localparam int DDR_LATENCY = 4;                          // Busy cycles before the access
    localparam int DDR_CNT_W   = $clog2(DDR_LATENCY + 2);    // Counter runs up to the done cycle

    // Counter values of the controller phases
    localparam logic [DDR_CNT_W-1:0] CNT_ACCESS  = DDR_CNT_W'(DDR_LATENCY - 1); // Bank strobe
    localparam logic [DDR_CNT_W-1:0] CNT_CAPTURE = DDR_CNT_W'(DDR_LATENCY);     // Line valid
    localparam logic [DDR_CNT_W-1:0] CNT_DONE    = DDR_CNT_W'(DDR_LATENCY + 1); // Done pulse

    // One request on the memory port
    typedef struct packed {
        logic [INDEX_W-1:0] index;   // Word index from the winning client
        logic               write;   // Store access
        logic               burst;   // Whole-line fetch for pc
        logic [WORD_W-1:0]  mask;    // Per-bit write enable
        logic [WORD_W-1:0]  data;    // Store data
    } ddr_req_t;

    // A line seen either as one instruction block or as separate words
    typedef union packed {
        logic [LINE_W-1:0]                  flat;   // Instruction line for pc
        logic [LINE_WORDS-1:0][WORD_W-1:0]  words;  // Word 0 sits in the low bits
    } line_t;

endpackage

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                        clk,
    input  logic                        arst_n,
    // pc channel
    input  logic                        pc_index_valid,
    input  logic [mem_pkg::INDEX_W-1:0] pc_index,
    output logic                        pc_index_ready,
    output logic [mem_pkg::LINE_W-1:0]  pc_read_inst,
    output logic                        pc_operation_done,
    // opstore channel
    input  logic                        opstore_index_valid,
    input  logic [mem_pkg::INDEX_W-1:0] opstore_index,
    output logic                        opstore_index_ready,
    input  logic [mem_pkg::WORD_W-1:0]  opstore_write_mask,
    input  logic [mem_pkg::WORD_W-1:0]  opstore_write_data,
    output logic                        opstore_operation_done,
    // opload channel
    input  logic                        opload_index_valid,
    input  logic [mem_pkg::INDEX_W-1:0] opload_index,
    output logic                        opload_index_ready,
    output logic [mem_pkg::WORD_W-1:0]  opload_read_data,
    output logic                        opload_operation_done
);
    import mem_pkg::*;

    logic     ddr_chip_enable;
    logic     ddr_ready;
    logic     ddr_operation_done;
    ddr_req_t ddr_req;         // Arbiter to controller
    logic     bank_we;
    logic     bank_re;
    ddr_req_t bank_req;        // Captured request, controller to bank
    line_t    bank_line;

    // One done strobe, every client sees it
    assign pc_operation_done      = ddr_operation_done;
    assign opstore_operation_done = ddr_operation_done;
    assign opload_operation_done  = ddr_operation_done;

    channel_arb u_arb (
        .clk, .arst_n,
        .pc_index_valid, .pc_index, .pc_index_ready,
        .opstore_index_valid, .opstore_index, .opstore_index_ready,
        .opstore_write_mask, .opstore_write_data,
        .opload_index_valid, .opload_index, .opload_index_ready,
        .ddr_ready, .ddr_chip_enable, .ddr_req
    );

    ddr_ctrl u_ctrl (
        .clk, .arst_n,
        .ddr_chip_enable, .ddr_req, .bank_line,
        .ddr_ready, .ddr_operation_done,
        .bank_we, .bank_re, .bank_req,
        .pc_read_inst, .opload_read_data
    );

    ddr_bank u_bank (
        .clk, .bank_we, .bank_re, .bank_req, .bank_line
    );

endmodule

//--- src.f
+incdir+test
source/mem_pkg.sv
source/channel_arb.sv
source/ddr_ctrl.sv
source/ddr_bank.sv
source/mem_subsys_top.sv
test/tb_mem_subsys.sv

//--- test/tb_mem_tests.svh
task automatic idle_inputs();
    pc_index_valid      = 1'b0;
    pc_index            = '0;
    opstore_index_valid = 1'b0;
    opstore_index       = '0;
    opstore_write_mask  = '0;
    opstore_write_data  = '0;
    opload_index_valid  = 1'b0;
    opload_index        = '0;
endtask

// Sets or drops one channel's request
task automatic drive_req(input int ch, input logic [INDEX_W-1:0] idx,
                         input logic [WORD_W-1:0] mask, input logic [WORD_W-1:0] data,
                         input logic valid);
    case (ch)
        CH_PC: begin
            pc_index_valid = valid;
            pc_index       = idx;
        end
        CH_STORE: begin
            opstore_index_valid = valid;
            opstore_index       = idx;
            opstore_write_mask  = mask;
            opstore_write_data  = data;
        end
        default: begin
            opload_index_valid = valid;
            opload_index       = idx;
        end
    endcase
endtask

function automatic logic ready_of(input int ch);
    if (ch == CH_PC) begin
        return pc_index_ready;
    end
    return (ch == CH_STORE) ? opstore_index_ready : opload_index_ready;
endfunction

function automatic logic all_done();
    return pc_operation_done && opstore_operation_done && opload_operation_done; // Broadcast
endfunction

// Starts on the first falling edge after the grant edge and counts edges to done
task automatic wait_done();
    int n;
    n = 1;
    #1;
    while (!all_done() && n < DDR_LATENCY + 2) begin
        if (pc_index_ready || opstore_index_ready || opload_index_ready) begin
            note_failure("A ready was high while an operation was outstanding");
        end
        @(negedge clk);
        #1;
        n++;
    end
    if (all_done()) begin
        check_value("done_latency", LINE_W'(n), LINE_W'(DDR_LATENCY + 2));
    end else begin
        note_failure("No done pulse arrived within the expected latency");
    end
endtask

// One complete operation on one channel
task automatic run_op(input int ch, input logic [INDEX_W-1:0] idx,
                      input logic [WORD_W-1:0] mask, input logic [WORD_W-1:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    drive_req(ch, idx, mask, data, 1'b1);
    #1;
    while (!ready_of(ch) && waited < GRANT_WAIT) begin
        @(negedge clk);
        #1;
        waited++;
    end
    if (!ready_of(ch)) begin
        note_failure("A channel never received its ready");
        idle_inputs();
    end else begin
        if (ch == CH_STORE) begin
            ref_write(idx, mask, data);
        end
        @(posedge clk);                      // Grant edge
        @(negedge clk);
        drive_req(ch, '0, '0, '0, 1'b0);
        wait_done();
    end
endtask

task automatic test_reset_state();
    int errs;
    errs = error_cnt;
    repeat (3) begin
        @(negedge clk);
        check_value("pc_index_ready", LINE_W'(pc_index_ready), '0);
        check_value("opstore_index_ready", LINE_W'(opstore_index_ready), '0);
        check_value("opload_index_ready", LINE_W'(opload_index_ready), '0);
        check_value("pc_operation_done", LINE_W'(pc_operation_done), '0);
        check_value("opstore_operation_done", LINE_W'(opstore_operation_done), '0);
        check_value("opload_operation_done", LINE_W'(opload_operation_done), '0);
        check_value("pc_read_inst", pc_read_inst, '0);
        check_value("opload_read_data", LINE_W'(opload_read_data), '0);
    end
    @(negedge clk);
    drive_req(CH_LOAD, INDEX_W'(3), '0, '0, 1'b1);
    #1;
    check_value("opload_index_ready", LINE_W'(opload_index_ready), LINE_W'(1)); // Same cycle
    @(posedge clk);
    @(negedge clk);
    idle_inputs();
    wait_done();
    end_test("reset_state", errs);
endtask

task automatic test_masked_store();
    int                 errs;
    logic [INDEX_W-1:0] idx;
    errs = error_cnt;
    idx = INDEX_W'(rand_bits(INDEX_W));
    run_op(CH_STORE, idx, '1, rand_bits(WORD_W));             // Known old word first
    run_op(CH_STORE, idx, rand_bits(WORD_W), rand_bits(WORD_W));
    run_op(CH_LOAD, idx, '0, '0);
    check_value("opload_read_data", LINE_W'(opload_read_data), LINE_W'(ref_read(idx)));
    end_test("masked_store", errs);
endtask

task automatic test_burst_fetch();
    int                 errs;
    logic [INDEX_W-1:0] base;
    logic [WORD_W-1:0]  word;
    logic [LINE_W-1:0]  expected;
    errs = error_cnt;
    base = INDEX_W'(rand_bits(INDEX_W - WORD_SEL_W) << WORD_SEL_W);  // Aligned line
    for (int w = 0; w < LINE_WORDS; w++) begin
        word = rand_bits(WORD_W);
        expected[w*WORD_W +: WORD_W] = word;
        run_op(CH_STORE, base + INDEX_W'(w), '1, word);
    end
    run_op(CH_PC, base | INDEX_W'(5), '0, '0);                // Fetch from mid-line
    check_value("pc_read_inst", pc_read_inst, expected);
    end_test("burst_fetch", errs);
endtask

task automatic test_priority();
    int                 errs;
    int                 ch;
    int                 waited;
    int                 order[$];
    logic [INDEX_W-1:0] ld_idx;
    logic [INDEX_W-1:0] pc_idx;
    logic [WORD_W-1:0]  st_mask;
    logic [WORD_W-1:0]  st_data;
    errs = error_cnt;
    waited = 0;
    ld_idx = INDEX_W'(rand_bits(INDEX_W));
    pc_idx = ld_idx ^ INDEX_W'(1);                            // Same line, other word
    st_mask = rand_bits(WORD_W);
    st_data = rand_bits(WORD_W);
    for (int w = 0; w < LINE_WORDS; w++) begin
        run_op(CH_STORE, {ld_idx[INDEX_W-1:WORD_SEL_W], WORD_SEL_W'(w)}, '1, rand_bits(WORD_W));
    end
    @(negedge clk);
    drive_req(CH_STORE, ld_idx, st_mask, st_data, 1'b1);      // All three at once
    drive_req(CH_LOAD, ld_idx, '0, '0, 1'b1);
    drive_req(CH_PC, pc_idx, '0, '0, 1'b1);
    while (order.size() < 3 && waited < 3 * GRANT_WAIT) begin
        #1;
        ch = opstore_index_ready ? CH_STORE : opload_index_ready ? CH_LOAD
           : pc_index_ready ? CH_PC : -1;
        if ($countones({pc_index_ready, opstore_index_ready, opload_index_ready}) > 1) begin
            note_failure("More than one ready was high in the same cycle");
        end
        if (ch < 0) begin
            @(negedge clk);
            waited++;
        end else begin
            order.push_back(ch);
            if (ch == CH_STORE) begin
                ref_write(ld_idx, st_mask, st_data);
            end
            @(posedge clk);
            @(negedge clk);
            drive_req(ch, '0, '0, '0, 1'b0);                  // Others keep waiting
            wait_done();
            if (ch == CH_LOAD) begin
                check_value("opload_read_data", LINE_W'(opload_read_data),
                            LINE_W'(ref_read(ld_idx)));
            end else if (ch == CH_PC) begin
                check_value("pc_read_inst", pc_read_inst, ref_line(pc_idx));
            end
        end
    end
    idle_inputs();
    if (order.size() != 3) begin
        note_failure("Not every waiting channel was granted");
    end else begin
        check_value("first_grant", LINE_W'(order[0]), LINE_W'(CH_STORE));
        check_value("second_grant", LINE_W'(order[1]), LINE_W'(CH_LOAD));
        check_value("third_grant", LINE_W'(order[2]), LINE_W'(CH_PC));
    end
    end_test("priority", errs);
endtask

task automatic test_random_mix();
    int                 errs;
    int                 kind;
    logic [INDEX_W-1:0] idx;
    errs = error_cnt;
    for (int w = 0; w < 16; w++) begin
        run_op(CH_STORE, INDEX_W'(w), '1, rand_bits(WORD_W)); // Known contents in range
    end
    repeat (30) begin
        kind = int'(rand_bits(2) % 3);
        idx = INDEX_W'((rand_bits(3) << BANK_DEPTH_LOG2) | rand_bits(4)); // Upper bits alias
        if (kind == 0) begin
            run_op(CH_STORE, idx, rand_bits(WORD_W), rand_bits(WORD_W));
        end else if (kind == 1) begin
            run_op(CH_LOAD, idx, '0, '0);
            check_value("opload_read_data", LINE_W'(opload_read_data), LINE_W'(ref_read(idx)));
        end else begin
            run_op(CH_PC, idx, '0, '0);
            check_value("pc_read_inst", pc_read_inst, ref_line(idx));
        end
    end
    end_test("random_mix", errs);
endtask

//--- test/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int CH_PC       = 0;
    localparam int CH_STORE    = 1;
    localparam int CH_LOAD     = 2;
    localparam int OP_CYCLES   = DDR_LATENCY + 4;            // Issue, busy, done, turnaround
    localparam int TOTAL_OPS   = 70;                         // Operations of all five tests
    localparam int CYCLE_LIMIT = TOTAL_OPS * OP_CYCLES + 100; // Margin for reset and idle checks
    localparam int GRANT_WAIT  = 2 * OP_CYCLES;              // Longest wait for a free port

    logic               clk;
    logic               arst_n;
    logic               pc_index_valid;
    logic [INDEX_W-1:0] pc_index;
    logic               pc_index_ready;
    logic [LINE_W-1:0]  pc_read_inst;
    logic               pc_operation_done;
    logic               opstore_index_valid;
    logic [INDEX_W-1:0] opstore_index;
    logic               opstore_index_ready;
    logic [WORD_W-1:0]  opstore_write_mask;
    logic [WORD_W-1:0]  opstore_write_data;
    logic               opstore_operation_done;
    logic               opload_index_valid;
    logic [INDEX_W-1:0] opload_index;
    logic               opload_index_ready;
    logic [WORD_W-1:0]  opload_read_data;
    logic               opload_operation_done;

    logic [WORD_W-1:0] ref_mem [int];   // Sparse model keyed by the wrapped index
    logic [31:0]       lfsr_state;
    int                error_cnt;
    int                check_cnt;
    int                test_cnt;
    int                cycle_cnt;

    mem_subsys_top dut (.*);

    always #5 clk = ~clk;                // 10 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);          // One step per bit
            v = {v[62:0], lfsr_state[31]};
        end
        return v;
    endfunction

    function automatic logic [WORD_W-1:0] ref_read(input logic [INDEX_W-1:0] idx);
        int key;
        key = int'(idx[BANK_DEPTH_LOG2-1:0]);            // Same wrap as the array
        if (ref_mem.exists(key)) begin
            return ref_mem[key];
        end
        return '0;
    endfunction

    task automatic ref_write(input logic [INDEX_W-1:0] idx, input logic [WORD_W-1:0] mask,
                             input logic [WORD_W-1:0] data);
        ref_mem[int'(idx[BANK_DEPTH_LOG2-1:0])] = (ref_read(idx) & ~mask) | (data & mask);
    endtask

    function automatic logic [LINE_W-1:0] ref_line(input logic [INDEX_W-1:0] idx);
        logic [LINE_W-1:0]     line;
        logic [WORD_SEL_W-1:0] sel;
        for (int w = 0; w < LINE_WORDS; w++) begin
            sel = WORD_SEL_W'(w);
            line[w*WORD_W +: WORD_W] = ref_read({idx[INDEX_W-1:WORD_SEL_W], sel}); // Word 0 low
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("Error: %s is %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic note_failure(input string what);
        error_cnt++;
        $display("%s", what);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("%s: finished with %0d errors", name, error_cnt - errs_before);
    endtask

    `include "tb_mem_tests.svh"

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        error_cnt = 0;
        check_cnt = 0;
        test_cnt  = 0;
        cycle_cnt = 0;
        lfsr_state = 32'd81131;
        idle_inputs();
        repeat (4) @(posedge clk);           // Reset held for 4 cycles
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_masked_store();
        test_burst_fetch();
        test_priority();
        test_random_mix();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
